/* logic/periph_pkg.sv */
// --------------------------------------------------------------------
// Peripheral domain package
// Bus widths, address map, register offsets and interrupt positions
// --------------------------------------------------------------------

`default_nettype none

package periph_pkg;

  localparam int unsigned DataWidth    = 32;
  localparam int unsigned AddrWidth    = 12;
  localparam int unsigned PageLsb      = 8;  // Bits 11:8 pick the peripheral
  localparam int unsigned RegLsb       = 2;
  localparam int unsigned RegAddrWidth = PageLsb - RegLsb;

  typedef logic [DataWidth-1:0]         data_t;
  typedef logic [AddrWidth-1:0]         addr_t;
  typedef logic [RegAddrWidth-1:0]      reg_addr_t;
  typedef logic [PageLsb-1:0]           reg_off_t;   // Byte offset in a page
  typedef logic [AddrWidth-PageLsb-1:0] page_t;

  typedef enum logic [1:0] {
    PeriphSocCtrl = 2'd0,
    PeriphGpio    = 2'd1,
    PeriphTimer   = 2'd2,
    PeriphError   = 2'd3
  } periph_idx_e;

  // Address map pages
  localparam page_t PageSocCtrl = 4'h0;
  localparam page_t PageGpio    = 4'h1;
  localparam page_t PageTimer   = 4'h2;

  localparam data_t ErrRspData = 32'hBADC_AB1E;

  // --------------------------------------------------------------------
  // Register offsets
  // --------------------------------------------------------------------
  localparam reg_off_t SocCtrlBootAddr = 8'h00;
  localparam reg_off_t SocCtrlFetchEn  = 8'h04;

  localparam reg_off_t GpioDir       = 8'h00;
  localparam reg_off_t GpioOut       = 8'h04;
  localparam reg_off_t GpioIn        = 8'h08;
  localparam reg_off_t GpioIrqEn     = 8'h0C;
  localparam reg_off_t GpioIrqStatus = 8'h10;

  localparam reg_off_t TimerCtrl   = 8'h00;  // bit0 enable, bit1 clear count
  localparam reg_off_t TimerCount  = 8'h04;
  localparam reg_off_t TimerCmp    = 8'h08;
  localparam reg_off_t TimerPresc  = 8'h0C;
  localparam reg_off_t TimerStatus = 8'h10;

  // Interrupt vector
  localparam int unsigned IrqTimer = 0;
  localparam int unsigned IrqGpio  = 1;
  localparam int unsigned NumIrqs  = 2;

endpackage

`default_nettype wire

/* logic/periph_reg_if.sv */
// --------------------------------------------------------------------
// Register access bus between the request FSM and one peripheral
// --------------------------------------------------------------------

`default_nettype none

interface periph_reg_if;

  logic                  sel;    // One cycle per access
  logic                  we;
  periph_pkg::reg_addr_t addr;   // Word offset
  periph_pkg::data_t     wdata;
  periph_pkg::data_t     rdata;  // Valid the cycle after sel

  modport fsm (
    output sel,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport periph (
    input  sel,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* logic/periph_obi_fsm.sv */
// --------------------------------------------------------------------
// OBI request FSM
// Grants one access at a time, decodes the page and returns the response
// --------------------------------------------------------------------

`default_nettype none

module periph_obi_fsm (
  input  logic              clk_i,
  input  logic              rst_n_i,

  input  logic              obi_req_i,
  input  logic              obi_we_i,
  input  periph_pkg::addr_t obi_addr_i,
  input  periph_pkg::data_t obi_wdata_i,
  output logic              obi_gnt_o,
  output logic              obi_rvalid_o,
  output periph_pkg::data_t obi_rdata_o,
  output logic              obi_err_o,

  periph_reg_if.fsm         ctrl_bus,
  periph_reg_if.fsm         gpio_bus,
  periph_reg_if.fsm         timer_bus
);

  typedef enum logic {
    StIdle,
    StRespond
  } state_e;

  state_e                  state_q;
  periph_pkg::periph_idx_e idx_d, idx_q;
  periph_pkg::reg_addr_t   reg_addr;
  logic                    grant;

  // Page decode
  always_comb begin
    case (obi_addr_i[periph_pkg::AddrWidth-1:periph_pkg::PageLsb])
      periph_pkg::PageSocCtrl: idx_d = periph_pkg::PeriphSocCtrl;
      periph_pkg::PageGpio:    idx_d = periph_pkg::PeriphGpio;
      periph_pkg::PageTimer:   idx_d = periph_pkg::PeriphTimer;
      default:                 idx_d = periph_pkg::PeriphError;
    endcase
  end

  assign obi_gnt_o = obi_req_i && (state_q == StIdle);
  assign grant     = obi_gnt_o;
  assign reg_addr  = obi_addr_i[periph_pkg::RegLsb +: periph_pkg::RegAddrWidth];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
    end else begin
      case (state_q)
        StIdle:    if (grant) state_q <= StRespond;
        default:   state_q <= StIdle;  // Response takes one cycle
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) idx_q <= idx_d;
  end

  // --------------------------------------------------------------------
  // Register buses
  // --------------------------------------------------------------------
  assign ctrl_bus.sel   = grant && (idx_d == periph_pkg::PeriphSocCtrl);
  assign ctrl_bus.we    = obi_we_i;
  assign ctrl_bus.addr  = reg_addr;
  assign ctrl_bus.wdata = obi_wdata_i;

  assign gpio_bus.sel   = grant && (idx_d == periph_pkg::PeriphGpio);
  assign gpio_bus.we    = obi_we_i;
  assign gpio_bus.addr  = reg_addr;
  assign gpio_bus.wdata = obi_wdata_i;

  assign timer_bus.sel   = grant && (idx_d == periph_pkg::PeriphTimer);
  assign timer_bus.we    = obi_we_i;
  assign timer_bus.addr  = reg_addr;
  assign timer_bus.wdata = obi_wdata_i;

  // Response mux
  always_comb begin
    case (idx_q)
      periph_pkg::PeriphSocCtrl: obi_rdata_o = ctrl_bus.rdata;
      periph_pkg::PeriphGpio:    obi_rdata_o = gpio_bus.rdata;
      periph_pkg::PeriphTimer:   obi_rdata_o = timer_bus.rdata;
      default:                   obi_rdata_o = periph_pkg::ErrRspData;
    endcase
  end

  assign obi_rvalid_o = (state_q == StRespond);
  assign obi_err_o    = obi_rvalid_o && (idx_q == periph_pkg::PeriphError);

endmodule

`default_nettype wire

/* logic/periph_soc_ctrl.sv */
// --------------------------------------------------------------------
// SoC control registers
// Boot address and fetch enable
// --------------------------------------------------------------------

`default_nettype none

module periph_soc_ctrl #(
  parameter periph_pkg::data_t BootAddrDefault = 32'h1000_0000
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  periph_reg_if.periph        bus,
  input  logic                fetch_en_i,
  output logic                fetch_enable_o,
  output periph_pkg::data_t   boot_addr_o
);

  periph_pkg::data_t    boot_addr_q;
  logic                 fetch_en_q;
  periph_pkg::data_t    rdata_q;
  periph_pkg::reg_off_t off;

  assign off = {bus.addr, 2'b00};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= BootAddrDefault;
      fetch_en_q  <= 1'b0;
    end else if (bus.sel && bus.we) begin
      case (off)
        periph_pkg::SocCtrlBootAddr: boot_addr_q <= bus.wdata;
        periph_pkg::SocCtrlFetchEn:  fetch_en_q  <= bus.wdata[0];
        default: ;
      endcase
    end
  end

  // Read data for the response cycle
  always_ff @(posedge clk_i) begin
    if (bus.sel) begin
      case (off)
        periph_pkg::SocCtrlBootAddr: rdata_q <= boot_addr_q;
        periph_pkg::SocCtrlFetchEn:  rdata_q <= {31'b0, fetch_en_q};
        default:                     rdata_q <= '0;
      endcase
    end
  end

  assign bus.rdata      = rdata_q;
  assign boot_addr_o    = boot_addr_q;
  assign fetch_enable_o = fetch_en_q | fetch_en_i;  // Pin can also start the core

endmodule

`default_nettype wire

/* logic/periph_gpio.sv */
// --------------------------------------------------------------------
// GPIO block
// Direction and output registers, synchronized inputs, edge interrupt
// --------------------------------------------------------------------

`default_nettype none

module periph_gpio #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  periph_reg_if.periph         bus,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o,
  output logic                 irq_o
);

  logic [GpioCount-1:0] dir_q, out_q, irq_en_q, irq_status_q;
  logic [GpioCount-1:0] sync1_q, sync2_q, prev_q;
  logic [GpioCount-1:0] rise, status_clr;
  periph_pkg::data_t    rdata_q;
  periph_pkg::reg_off_t off;
  logic                 wr;

  assign off = {bus.addr, 2'b00};
  assign wr  = bus.sel && bus.we;

  // Two flop synchronizer plus one stage for edge detect
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign rise       = sync2_q & ~prev_q & irq_en_q;
  assign status_clr = (wr && off == periph_pkg::GpioIrqStatus) ?
                      bus.wdata[GpioCount-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dir_q        <= '0;
      out_q        <= '0;
      irq_en_q     <= '0;
      irq_status_q <= '0;
    end else begin
      irq_status_q <= (irq_status_q & ~status_clr) | rise;  // New edge wins
      if (wr) begin
        case (off)
          periph_pkg::GpioDir:   dir_q    <= bus.wdata[GpioCount-1:0];
          periph_pkg::GpioOut:   out_q    <= bus.wdata[GpioCount-1:0];
          periph_pkg::GpioIrqEn: irq_en_q <= bus.wdata[GpioCount-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.sel) begin
      case (off)
        periph_pkg::GpioDir:       rdata_q <= periph_pkg::data_t'(dir_q);
        periph_pkg::GpioOut:       rdata_q <= periph_pkg::data_t'(out_q);
        periph_pkg::GpioIn:        rdata_q <= periph_pkg::data_t'(sync2_q);
        periph_pkg::GpioIrqEn:     rdata_q <= periph_pkg::data_t'(irq_en_q);
        periph_pkg::GpioIrqStatus: rdata_q <= periph_pkg::data_t'(irq_status_q);
        default:                   rdata_q <= '0;
      endcase
    end
  end

  assign bus.rdata      = rdata_q;
  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = sync2_q;
  assign irq_o          = |(irq_status_q & irq_en_q);

endmodule

`default_nettype wire

/* logic/periph_timer.sv */
// --------------------------------------------------------------------
// Compare timer
// Prescaled 32 bit count that wraps at the compare value
// --------------------------------------------------------------------

`default_nettype none

module periph_timer (
  input  logic         clk_i,
  input  logic         rst_n_i,
  periph_reg_if.periph bus,
  output logic         irq_o
);

  logic                 en_q, status_q;
  periph_pkg::data_t    presc_q, presc_cnt_q;
  periph_pkg::data_t    count_q, cmp_q;
  periph_pkg::data_t    rdata_q;
  periph_pkg::reg_off_t off;
  logic                 wr, tick, wrap, clr_cnt;

  assign off     = {bus.addr, 2'b00};
  assign wr      = bus.sel && bus.we;
  assign tick    = en_q && (presc_cnt_q == presc_q);
  assign wrap    = tick && (count_q == cmp_q);
  assign clr_cnt = wr && (off == periph_pkg::TimerCtrl) && bus.wdata[1];

  // --------------------------------------------------------------------
  // Counters
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      presc_cnt_q <= '0;
      count_q     <= '0;
    end else if (clr_cnt) begin
      presc_cnt_q <= '0;
      count_q     <= '0;
    end else begin
      if (en_q) presc_cnt_q <= tick ? '0 : presc_cnt_q + 1'b1;
      if (wr && off == periph_pkg::TimerCount) begin
        count_q <= bus.wdata;  // Load beats the tick
      end else if (wrap) begin
        count_q <= '0;
      end else if (tick) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // Config and status
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q     <= 1'b0;
      cmp_q    <= '0;
      presc_q  <= '0;
      status_q <= 1'b0;
    end else begin
      if (wrap) begin
        status_q <= 1'b1;
      end else if (wr && off == periph_pkg::TimerStatus && bus.wdata[0]) begin
        status_q <= 1'b0;
      end
      if (wr) begin
        case (off)
          periph_pkg::TimerCtrl:  en_q    <= bus.wdata[0];
          periph_pkg::TimerCmp:   cmp_q   <= bus.wdata;
          periph_pkg::TimerPresc: presc_q <= bus.wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.sel) begin
      case (off)
        periph_pkg::TimerCtrl:   rdata_q <= {31'b0, en_q};  // Clear bit reads 0
        periph_pkg::TimerCount:  rdata_q <= count_q;
        periph_pkg::TimerCmp:    rdata_q <= cmp_q;
        periph_pkg::TimerPresc:  rdata_q <= presc_q;
        periph_pkg::TimerStatus: rdata_q <= {31'b0, status_q};
        default:                 rdata_q <= '0;
      endcase
    end
  end

  assign bus.rdata = rdata_q;
  assign irq_o     = status_q;

endmodule

`default_nettype wire

/* logic/periph_domain.sv */
// --------------------------------------------------------------------
// Peripheral domain top level
// OBI port, SoC control, GPIO, timer and the interrupt vector
// --------------------------------------------------------------------

`default_nettype none

module periph_domain #(
  parameter int unsigned       GpioCount       = 16,
  parameter periph_pkg::data_t BootAddrDefault = 32'h1000_0000
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,

  // OBI subordinate port
  input  logic                           obi_req_i,
  input  logic                           obi_we_i,
  input  periph_pkg::addr_t              obi_addr_i,
  input  periph_pkg::data_t              obi_wdata_i,
  output logic                           obi_gnt_o,
  output logic                           obi_rvalid_o,
  output periph_pkg::data_t              obi_rdata_o,
  output logic                           obi_err_o,

  input  logic                           fetch_en_i,
  output logic                           fetch_enable_o,
  output periph_pkg::data_t              boot_addr_o,

  input  logic [GpioCount-1:0]           gpio_i,
  output logic [GpioCount-1:0]           gpio_o,
  output logic [GpioCount-1:0]           gpio_out_en_o,
  output logic [GpioCount-1:0]           gpio_in_sync_o,

  output logic [periph_pkg::NumIrqs-1:0] irq_o
);

  logic gpio_irq;
  logic timer_irq;

  periph_reg_if ctrl_bus ();
  periph_reg_if gpio_bus ();
  periph_reg_if timer_bus ();

  // --------------------------------------------------------------------
  // Request FSM
  // --------------------------------------------------------------------
  periph_obi_fsm i_obi_fsm (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .obi_req_i    ( obi_req_i    ),
    .obi_we_i     ( obi_we_i     ),
    .obi_addr_i   ( obi_addr_i   ),
    .obi_wdata_i  ( obi_wdata_i  ),
    .obi_gnt_o    ( obi_gnt_o    ),
    .obi_rvalid_o ( obi_rvalid_o ),
    .obi_rdata_o  ( obi_rdata_o  ),
    .obi_err_o    ( obi_err_o    ),
    .ctrl_bus     ( ctrl_bus     ),
    .gpio_bus     ( gpio_bus     ),
    .timer_bus    ( timer_bus    )
  );

  // --------------------------------------------------------------------
  // Peripherals
  // --------------------------------------------------------------------
  periph_soc_ctrl #(
    .BootAddrDefault ( BootAddrDefault )
  ) i_soc_ctrl (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .bus            ( ctrl_bus       ),
    .fetch_en_i     ( fetch_en_i     ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  periph_gpio #(
    .GpioCount ( GpioCount )
  ) i_gpio (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .bus            ( gpio_bus       ),
    .gpio_i         ( gpio_i         ),
    .gpio_o         ( gpio_o         ),
    .gpio_out_en_o  ( gpio_out_en_o  ),
    .gpio_in_sync_o ( gpio_in_sync_o ),
    .irq_o          ( gpio_irq       )
  );

  periph_timer i_timer (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .bus     ( timer_bus ),
    .irq_o   ( timer_irq )
  );

  // Interrupt vector
  always_comb begin
    irq_o                      = '0;
    irq_o[periph_pkg::IrqTimer] = timer_irq;
    irq_o[periph_pkg::IrqGpio]  = gpio_irq;
  end

endmodule

`default_nettype wire

/* tests/periph_domain_tb.sv */
// --------------------------------------------------------------------
// Peripheral domain testbench
// Drives the OBI port and checks SoC control, GPIO, timer and errors
// --------------------------------------------------------------------

`default_nettype none

module periph_domain_tb;

  localparam int unsigned       ClkPeriod       = 8;
  localparam int unsigned       GpioCount       = 16;
  localparam periph_pkg::data_t BootAddrDefault = 32'h2000_0100;
  localparam int unsigned       AccessTimeout   = 16;
  localparam int unsigned       IrqWaitCycles   = 8;
  localparam int unsigned       TimerCmpVal     = 24;
  localparam int unsigned       TimerWaitCycles = 4 * (TimerCmpVal + 1);
  localparam int unsigned       NumTests        = 6;
  localparam int unsigned       WatchdogCycles  = NumTests * 200 + TimerWaitCycles;

  logic                           clk_i;
  logic                           rst_n_i;
  logic                           obi_req_i;
  logic                           obi_we_i;
  periph_pkg::addr_t              obi_addr_i;
  periph_pkg::data_t              obi_wdata_i;
  logic                           obi_gnt_o;
  logic                           obi_rvalid_o;
  periph_pkg::data_t              obi_rdata_o;
  logic                           obi_err_o;
  logic                           fetch_en_i;
  logic                           fetch_enable_o;
  periph_pkg::data_t              boot_addr_o;
  logic [GpioCount-1:0]           gpio_i;
  logic [GpioCount-1:0]           gpio_o;
  logic [GpioCount-1:0]           gpio_out_en_o;
  logic [GpioCount-1:0]           gpio_in_sync_o;
  logic [periph_pkg::NumIrqs-1:0] irq_o;

  int          errors;
  logic [15:0] lfsr_state;

  periph_domain #(
    .GpioCount       ( GpioCount       ),
    .BootAddrDefault ( BootAddrDefault )
  ) UUT (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .obi_req_i      ( obi_req_i      ),
    .obi_we_i       ( obi_we_i       ),
    .obi_addr_i     ( obi_addr_i     ),
    .obi_wdata_i    ( obi_wdata_i    ),
    .obi_gnt_o      ( obi_gnt_o      ),
    .obi_rvalid_o   ( obi_rvalid_o   ),
    .obi_rdata_o    ( obi_rdata_o    ),
    .obi_err_o      ( obi_err_o      ),
    .fetch_en_i     ( fetch_en_i     ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    ),
    .gpio_i         ( gpio_i         ),
    .gpio_o         ( gpio_o         ),
    .gpio_out_en_o  ( gpio_out_en_o  ),
    .gpio_in_sync_o ( gpio_in_sync_o ),
    .irq_o          ( irq_o          )
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // --------------------------------------------------------------------
  // OBI handshake rules
  // --------------------------------------------------------------------
  assert property (@(posedge clk_i) disable iff (!rst_n_i) obi_gnt_o |=> obi_rvalid_o)
    else begin
      errors++;
      $display("Handshake error at %0t: no rvalid in the cycle after a grant", $time);
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) obi_rvalid_o |-> $past(obi_gnt_o))
    else begin
      errors++;
      $display("Handshake error at %0t: rvalid without a grant before it", $time);
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) obi_rvalid_o |=> !obi_rvalid_o)
    else begin
      errors++;
      $display("Handshake error at %0t: rvalid held for more than one cycle", $time);
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) obi_rvalid_o |-> !obi_gnt_o)
    else begin
      errors++;
      $display("Handshake error at %0t: grant during the response cycle", $time);
    end

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic periph_pkg::data_t rand_bits(input int unsigned nbits);
    periph_pkg::data_t val;
    int unsigned       i;
    val = '0;
    for (i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val        = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  function automatic periph_pkg::addr_t make_addr(input periph_pkg::page_t page,
                                                  input periph_pkg::reg_off_t off);
    return {page, off};
  endfunction

  task automatic check_word(input string what, input periph_pkg::data_t got,
                            input periph_pkg::data_t exp);
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // One OBI access with req held until the grant
  task automatic bus_access(input logic we, input periph_pkg::addr_t addr,
                            input periph_pkg::data_t wdata,
                            output periph_pkg::data_t rdata);
    int unsigned waits;
    logic        exp_err;
    exp_err = (addr[11:8] > 4'h2);  // Pages above the timer are unmapped
    waits   = 0;
    @(posedge clk_i);
    #1;
    obi_req_i   = 1'b1;
    obi_we_i    = we;
    obi_addr_i  = addr;
    obi_wdata_i = wdata;
    @(negedge clk_i);
    while (!obi_gnt_o && waits < AccessTimeout) begin
      @(negedge clk_i);
      waits++;
    end
    assert (obi_gnt_o) else begin
      errors++;
      $display("Handshake error at %0t: request to %h was never granted", $time, addr);
    end
    @(posedge clk_i);
    #1;
    obi_req_i = 1'b0;
    waits     = 0;
    @(negedge clk_i);
    while (!obi_rvalid_o && waits < AccessTimeout) begin
      @(negedge clk_i);
      waits++;
    end
    assert (obi_rvalid_o) else begin
      errors++;
      $display("Handshake error at %0t: no response for address %h", $time, addr);
    end
    rdata = obi_rdata_o;
    assert (obi_err_o === exp_err) else begin
      errors++;
      $display("Mismatch at %0t: err is %b for address %h, expected %b",
               $time, obi_err_o, addr, exp_err);
    end
  endtask

  task automatic obi_write(input periph_pkg::addr_t addr, input periph_pkg::data_t wdata);
    periph_pkg::data_t unused;
    bus_access(1'b1, addr, wdata, unused);
  endtask

  task automatic obi_read(input periph_pkg::addr_t addr, output periph_pkg::data_t rdata);
    bus_access(1'b0, addr, '0, rdata);
  endtask

  task automatic read_check(input periph_pkg::addr_t addr, input periph_pkg::data_t exp,
                            input string what);
    periph_pkg::data_t rd;
    obi_read(addr, rd);
    check_word(what, rd, exp);
  endtask

  // Watchdog
  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout: the run did not finish within %0d cycles", WatchdogCycles);
    $display("Checks failed");
    $finish;
  end

  initial begin
    periph_pkg::data_t    w, last_boot, rd, rd2;
    periph_pkg::reg_off_t off;
    logic [GpioCount-1:0] pins, old_pins;
    int unsigned          i, p, k, cycles;

    errors      = 0;
    lfsr_state  = 16'd37133;
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    obi_req_i   = 1'b0;
    obi_we_i    = 1'b0;
    obi_addr_i  = '0;
    obi_wdata_i = '0;
    fetch_en_i  = 1'b0;
    gpio_i      = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // ------------------------------------------------------------------
    // Reset values and a held request
    // ------------------------------------------------------------------
    @(negedge clk_i);
    check_word("irq_o", periph_pkg::data_t'(irq_o), '0);
    check_word("gpio_o", periph_pkg::data_t'(gpio_o), '0);
    check_word("gpio_out_en_o", periph_pkg::data_t'(gpio_out_en_o), '0);
    check_word("boot_addr_o", boot_addr_o, BootAddrDefault);
    check_word("fetch_enable_o", periph_pkg::data_t'(fetch_enable_o), '0);
    @(posedge clk_i);
    #1;
    fetch_en_i = 1'b1;
    @(negedge clk_i);
    check_word("fetch_enable_o from pin", periph_pkg::data_t'(fetch_enable_o), 32'h1);
    @(posedge clk_i);
    #1;
    fetch_en_i  = 1'b0;
    obi_req_i   = 1'b1;
    obi_we_i    = 1'b0;
    obi_addr_i  = make_addr(periph_pkg::PageSocCtrl, periph_pkg::SocCtrlBootAddr);
    cycles      = 0;
    for (i = 0; i < 6; i++) begin
      @(negedge clk_i);
      if (obi_gnt_o) cycles++;
    end
    check_word("grants for a held request", periph_pkg::data_t'(cycles), 32'd3);
    @(posedge clk_i);
    #1;
    obi_req_i = 1'b0;

    // ------------------------------------------------------------------
    // SoC control
    // ------------------------------------------------------------------
    for (i = 0; i < 4; i++) begin
      w = rand_bits(32);
      obi_write(make_addr(periph_pkg::PageSocCtrl, periph_pkg::SocCtrlBootAddr), w);
      read_check(make_addr(periph_pkg::PageSocCtrl, periph_pkg::SocCtrlBootAddr), w,
                 "BootAddr");
      check_word("boot_addr_o", boot_addr_o, w);
    end
    last_boot = w;
    obi_write(make_addr(periph_pkg::PageSocCtrl, periph_pkg::SocCtrlFetchEn), 32'h1);
    check_word("fetch_enable_o from register", periph_pkg::data_t'(fetch_enable_o), 32'h1);
    read_check(make_addr(periph_pkg::PageSocCtrl, periph_pkg::SocCtrlFetchEn), 32'h1,
               "FetchEn");
    obi_write(make_addr(periph_pkg::PageSocCtrl, periph_pkg::SocCtrlFetchEn), 32'h0);
    check_word("fetch_enable_o cleared", periph_pkg::data_t'(fetch_enable_o), '0);

    // Error pages
    for (p = 3; p < 16; p++) begin
      obi_write(make_addr(periph_pkg::page_t'(p), periph_pkg::SocCtrlBootAddr), rand_bits(32));
      off = periph_pkg::reg_off_t'({rand_bits(6), 2'b00});
      read_check(make_addr(periph_pkg::page_t'(p), off), periph_pkg::ErrRspData,
                 "error page read");
    end
    read_check(make_addr(periph_pkg::PageSocCtrl, periph_pkg::SocCtrlBootAddr), last_boot,
               "BootAddr after error writes");

    // ------------------------------------------------------------------
    // GPIO outputs and inputs
    // ------------------------------------------------------------------
    for (i = 0; i < 3; i++) begin
      w = rand_bits(GpioCount);
      obi_write(make_addr(periph_pkg::PageGpio, periph_pkg::GpioDir), w);
      check_word("gpio_out_en_o", periph_pkg::data_t'(gpio_out_en_o), w);
      w = rand_bits(GpioCount);
      obi_write(make_addr(periph_pkg::PageGpio, periph_pkg::GpioOut), w);
      check_word("gpio_o", periph_pkg::data_t'(gpio_o), w);
      read_check(make_addr(periph_pkg::PageGpio, periph_pkg::GpioOut), w, "GpioOut");
      pins     = GpioCount'(rand_bits(GpioCount));
      old_pins = gpio_i;
      @(posedge clk_i);
      #1;
      gpio_i = pins;
      @(posedge clk_i);
      @(negedge clk_i);
      check_word("gpio_in_sync_o after one edge", periph_pkg::data_t'(gpio_in_sync_o),
                 periph_pkg::data_t'(old_pins));
      @(posedge clk_i);  // Sync output settles on the second edge
      @(negedge clk_i);
      check_word("gpio_in_sync_o", periph_pkg::data_t'(gpio_in_sync_o),
                 periph_pkg::data_t'(pins));
      read_check(make_addr(periph_pkg::PageGpio, periph_pkg::GpioIn),
                 periph_pkg::data_t'(pins), "GpioIn");
    end

    // GPIO rising edge interrupt
    @(posedge clk_i);
    #1;
    gpio_i = '0;
    repeat (4) @(posedge clk_i);
    k = rand_bits(4);
    obi_write(make_addr(periph_pkg::PageGpio, periph_pkg::GpioIrqEn), 32'h1 << k);
    check_word("gpio irq before edge", periph_pkg::data_t'(irq_o[periph_pkg::IrqGpio]), '0);
    @(posedge clk_i);
    #1;
    gpio_i[k] = 1'b1;
    cycles    = 0;
    while (!irq_o[periph_pkg::IrqGpio] && cycles < IrqWaitCycles) begin
      @(negedge clk_i);
      cycles++;
    end
    check_word("gpio irq after edge", periph_pkg::data_t'(irq_o[periph_pkg::IrqGpio]), 32'h1);
    read_check(make_addr(periph_pkg::PageGpio, periph_pkg::GpioIrqStatus), 32'h1 << k,
               "GpioIrqStatus");
    obi_write(make_addr(periph_pkg::PageGpio, periph_pkg::GpioIrqStatus), 32'h1 << k);
    check_word("gpio irq cleared", periph_pkg::data_t'(irq_o[periph_pkg::IrqGpio]), '0);

    // ------------------------------------------------------------------
    // Timer
    // ------------------------------------------------------------------
    obi_write(make_addr(periph_pkg::PageTimer, periph_pkg::TimerPresc), '0);
    obi_write(make_addr(periph_pkg::PageTimer, periph_pkg::TimerCmp), TimerCmpVal);
    obi_write(make_addr(periph_pkg::PageTimer, periph_pkg::TimerCtrl), 32'h3);
    cycles = 0;
    // Count starts at 0 on the enable edge and wraps after Cmp+1 advances
    while (!irq_o[periph_pkg::IrqTimer] && cycles < TimerWaitCycles) begin
      @(negedge clk_i);
      cycles++;
    end
    check_word("cycles until timer irq", periph_pkg::data_t'(cycles), TimerCmpVal + 1);
    obi_read(make_addr(periph_pkg::PageTimer, periph_pkg::TimerCount), rd);
    assert (rd <= TimerCmpVal) else begin
      errors++;
      $display("Mismatch at %0t: Count is %0d, above Cmp %0d", $time, rd, TimerCmpVal);
    end
    obi_write(make_addr(periph_pkg::PageTimer, periph_pkg::TimerStatus), 32'h1);
    check_word("timer irq cleared", periph_pkg::data_t'(irq_o[periph_pkg::IrqTimer]), '0);
    obi_write(make_addr(periph_pkg::PageTimer, periph_pkg::TimerCtrl), 32'h0);
    obi_read(make_addr(periph_pkg::PageTimer, periph_pkg::TimerCount), rd);
    repeat (TimerCmpVal + 2) @(posedge clk_i);  // A running timer would wrap here
    obi_read(make_addr(periph_pkg::PageTimer, periph_pkg::TimerCount), rd2);
    check_word("Count while disabled", rd2, rd);
    check_word("timer irq while disabled", periph_pkg::data_t'(irq_o[periph_pkg::IrqTimer]), '0);

    repeat (2) @(posedge clk_i);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* periph_domain.f */
logic/periph_pkg.sv
logic/periph_reg_if.sv
logic/periph_obi_fsm.sv
logic/periph_soc_ctrl.sv
logic/periph_gpio.sv
logic/periph_timer.sv
logic/periph_domain.sv
tests/periph_domain_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= periph_domain_tb
FILELIST  ?= periph_domain.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
